// File: hdl/knightCmd_defs.svh
`ifndef KNIGHTCMD_DEFS_SVH
`define KNIGHTCMD_DEFS_SVH

////////////////////////////////////////////////////////////
// Buffer sizing and executor timing
////////////////////////////////////////////////////////////
// Command slots in the buffer and the initial credit count
`define FIFO_DEPTH 4
// Clocks spent on a calibrate
`define CAL_CYCLES 64
// Clocks per square of motion
`define MOVE_CYCLES 16

////////////////////////////////////////////////////////////
// Command and response encodings
////////////////////////////////////////////////////////////
`define OP_CAL  4'h2
`define OP_MOVE 4'h4
`define OP_TOUR 4'h6

// Headings and the axis each one steps along
`define HDG_NORTH 8'h00
`define HDG_WEST  8'h3F
`define HDG_SOUTH 8'h7F
`define HDG_EAST  8'hBF

`define ACK_POS 8'hA5
`define ACK_NEG 8'hEE

// Knight starts near the lower left corner
`define RESET_X 2
`define RESET_Y 2

`endif

// File: hdl/knightPkg.sv
`default_nettype none

package knightPkg;

  ////////////////////////////////////////////////////////////
  // Command word views
  ////////////////////////////////////////////////////////////

  // Move view
  typedef struct packed {
    logic [3:0] opcode;
    logic [7:0] heading;
    logic [3:0] squares;
  } moveCmdT;

  // Start-tour view
  // Only bits [2:0] of each coordinate reach the board
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rsvd;
    logic [3:0] startX;
    logic [3:0] startY;
  } tourCmdT;

  // One 16-bit command word, read either way
  // Opcode sits in the same nibble in both views
  typedef union packed {
    moveCmdT move;
    tourCmdT tour;
  } knightCmdU;

endpackage

`default_nettype wire

// File: hdl/cmdAssembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "knightCmd_defs.svh"

module cmdAssembler (
  input  logic               clk,
  input  logic               rstN,
  input  logic [7:0]         rxByte,
  input  logic               rxValid,
  output logic               rxReady,
  input  logic               creditRet,
  output logic               push,
  output knightPkg::knightCmdU cmdIn
);

  // Credit counter spans 0 to FIFO_DEPTH
  localparam int CreditW = $clog2(`FIFO_DEPTH + 1);

  logic               lowPhase;   // next byte taken is the low byte
  logic [7:0]         hiByte;
  logic               cmdPend;    // assembled command not yet pushed
  logic [CreditW-1:0] creditCnt;
  logic               haveCredit;
  logic               byteTaken;

  ////////////////////////////////////////////////////////////
  // Handshake and push
  ////////////////////////////////////////////////////////////
  assign haveCredit = (creditCnt != '0);
  // Stall only while a finished command waits on credit
  assign rxReady    = !cmdPend || haveCredit;
  assign byteTaken  = rxValid && rxReady;
  assign push       = cmdPend && haveCredit;

  // Byte phase, pending flag and credits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      lowPhase  <= 1'b0;
      cmdPend   <= 1'b0;
      creditCnt <= CreditW'(`FIFO_DEPTH);
    end else begin
      if (byteTaken)
        lowPhase <= !lowPhase;
      // A new low byte refills the slot as the old command leaves
      if (byteTaken && lowPhase)
        cmdPend <= 1'b1;
      else if (push)
        cmdPend <= 1'b0;
      // Spend and return may land on the same clock
      case ({push, creditRet})
        2'b10:   creditCnt <= creditCnt - 1'b1;
        2'b01:   creditCnt <= creditCnt + 1'b1;
        default: creditCnt <= creditCnt;
      endcase
    end
  end

  // Byte registers
  always_ff @(posedge clk) begin
    if (byteTaken && !lowPhase)
      hiByte <= rxByte;
    if (byteTaken && lowPhase)
      cmdIn <= {hiByte, rxByte};
  end

endmodule

`default_nettype wire

// File: hdl/cmdFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "knightCmd_defs.svh"

module cmdFifo (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 push,
  input  knightPkg::knightCmdU cmdIn,
  input  logic                 pop,
  output knightPkg::knightCmdU cmdOut,
  output logic                 notEmpty,
  output logic                 creditRet
);

  import knightPkg::*;

  localparam int Depth  = `FIFO_DEPTH;
  localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountW = $clog2(Depth + 1);

  knightCmdU          mem [Depth];
  logic [PtrW-1:0]    wrPtr;
  logic [PtrW-1:0]    rdPtr;
  logic [CountW-1:0]  count;
  logic               doPop;

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////
  assign notEmpty = (count != '0);
  assign cmdOut   = mem[rdPtr];
  // Ignore a pop on an empty buffer
  assign doPop    = pop && notEmpty;

  // Storage
  // Credits bound the pushes so a full buffer never sees one
  always_ff @(posedge clk) begin
    if (push)
      mem[wrPtr] <= cmdIn;
  end

  // Pointers, occupancy and credit return
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      creditRet <= 1'b0;
    end else begin
      if (push)
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per slot freed
      creditRet <= doPop;
    end
  end

endmodule

`default_nettype wire

// File: hdl/moveExecutor.sv
`timescale 1ns/1ps
`default_nettype none

`include "knightCmd_defs.svh"

module moveExecutor (
  input  logic                 clk,
  input  logic                 rstN,
  input  knightPkg::knightCmdU cmdOut,
  input  logic                 notEmpty,
  output logic                 pop,
  output logic                 respValid,
  output logic [7:0]           respByte,
  output logic [2:0]           posX,
  output logic [2:0]           posY
);

  import knightPkg::*;

  localparam int CalCycles  = `CAL_CYCLES;
  localparam int MoveCycles = `MOVE_CYCLES;
  // Longest wait is either a calibrate or a 15-square move
  localparam int MaxLat = (CalCycles > 15 * MoveCycles) ? CalCycles : 15 * MoveCycles;
  localparam int CntW   = $clog2(MaxLat + 1);

  localparam logic [1:0] Idle    = 2'd0;
  localparam logic [1:0] Busy    = 2'd1;
  localparam logic [1:0] Respond = 2'd2;

  logic [1:0]      state;
  logic [CntW-1:0] cnt;
  logic [3:0]      sq;
  logic [4:0]      upX;
  logic [4:0]      upY;
  logic            moveOk;
  logic [2:0]      tgtX;
  logic [2:0]      tgtY;
  logic [CntW-1:0] decLat;
  logic [2:0]      decX;
  logic [2:0]      decY;
  logic [7:0]      decResp;
  logic [2:0]      nxtX;
  logic [2:0]      nxtY;

  assign pop       = (state == Idle) && notEmpty;
  assign respValid = (state == Respond);

  ////////////////////////////////////////////////////////////
  // Move target and legality
  ////////////////////////////////////////////////////////////
  assign sq  = cmdOut.move.squares;
  assign upX = {2'b00, posX} + {1'b0, sq};
  assign upY = {2'b00, posY} + {1'b0, sq};

  always_comb begin
    moveOk = 1'b0;
    tgtX   = posX;
    tgtY   = posY;
    case (cmdOut.move.heading)
      `HDG_NORTH: begin
        moveOk = (upY <= 5'd7);
        tgtY   = upY[2:0];
      end
      `HDG_SOUTH: begin
        moveOk = (sq <= {1'b0, posY});
        tgtY   = posY - sq[2:0];
      end
      `HDG_EAST: begin
        moveOk = (upX <= 5'd7);
        tgtX   = upX[2:0];
      end
      `HDG_WEST: begin
        moveOk = (sq <= {1'b0, posX});
        tgtX   = posX - sq[2:0];
      end
      default: moveOk = 1'b0;
    endcase
    // Zero squares is not a move
    if (sq == 4'd0)
      moveOk = 1'b0;
  end

  // Opcode decode through the union
  always_comb begin
    decLat  = CntW'(1);
    decX    = posX;
    decY    = posY;
    decResp = `ACK_NEG;
    case (cmdOut.move.opcode)
      `OP_CAL: begin
        decLat  = CntW'(CalCycles);
        decResp = `ACK_POS;
      end
      `OP_TOUR: begin
        decX    = cmdOut.tour.startX[2:0];
        decY    = cmdOut.tour.startY[2:0];
        decResp = `ACK_POS;
      end
      `OP_MOVE: begin
        if (moveOk) begin
          decLat  = CntW'(sq) * CntW'(MoveCycles);
          decX    = tgtX;
          decY    = tgtY;
          decResp = `ACK_POS;
        end
      end
      default: decResp = `ACK_NEG;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // FSM, countdown and board square
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= Idle;
      cnt   <= '0;
      posX  <= 3'(`RESET_X);
      posY  <= 3'(`RESET_Y);
    end else begin
      case (state)
        Idle: begin
          if (notEmpty) begin
            if (decLat > CntW'(1)) begin
              state <= Busy;
              // Busy plus Respond fill out the latency
              cnt   <= decLat - CntW'(2);
            end else begin
              state <= Respond;
              posX  <= decX;
              posY  <= decY;
            end
          end
        end
        Busy: begin
          if (cnt == '0) begin
            state <= Respond;
            // Square changes together with respValid
            posX  <= nxtX;
            posY  <= nxtY;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Response code and pending square, captured at pop
  always_ff @(posedge clk) begin
    if (pop) begin
      respByte <= decResp;
      nxtX     <= decX;
      nxtY     <= decY;
    end
  end

endmodule

`default_nettype wire

// File: hdl/knightCmdTop.sv
`timescale 1ns/1ps
`default_nettype none

module knightCmdTop (
  input  logic       clk,
  input  logic       rstN,
  input  logic [7:0] rxByte,
  input  logic       rxValid,
  output logic       rxReady,
  output logic       respValid,
  output logic [7:0] respByte,
  output logic [2:0] posX,
  output logic [2:0] posY
);

  import knightPkg::*;

  // Assembler to buffer
  logic      push;
  knightCmdU cmdIn;
  logic      creditRet;
  // Buffer to executor
  knightCmdU cmdOut;
  logic      notEmpty;
  logic      pop;

  ////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  ////////////////////////////////////////////////////////////
  cmdAssembler u_cmdAssembler (
    .clk(clk), .rstN(rstN),
    .rxByte(rxByte), .rxValid(rxValid), .rxReady(rxReady),
    .creditRet(creditRet), .push(push), .cmdIn(cmdIn)
  );

  cmdFifo u_cmdFifo (
    .clk(clk), .rstN(rstN),
    .push(push), .cmdIn(cmdIn),
    .pop(pop), .cmdOut(cmdOut), .notEmpty(notEmpty),
    .creditRet(creditRet)
  );

  // Response is a bare pulse with no back-pressure
  moveExecutor u_moveExecutor (
    .clk(clk), .rstN(rstN),
    .cmdOut(cmdOut), .notEmpty(notEmpty), .pop(pop),
    .respValid(respValid), .respByte(respByte),
    .posX(posX), .posY(posY)
  );

endmodule

`default_nettype wire

// File: tb/knightCmdChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "knightCmd_defs.svh"

module knightCmdChecker (
  input  logic       clk,
  input  logic       rstN,
  input  logic [7:0] rxByte,
  input  logic       rxValid,
  input  logic       rxReady,
  input  logic       respValid,
  input  logic [7:0] respByte,
  input  logic [2:0] posX,
  input  logic [2:0] posY,
  input  int         testId,
  input  logic       testEnd,
  output int         pending,
  output int         errCount,
  output int         cmdCount,
  output logic [2:0] planX,
  output logic [2:0] planY
);

  import knightPkg::*;

  logic        lowPhase;
  logic [7:0]  hiByte;
  logic [2:0]  lastX;
  logic [2:0]  lastY;
  // Expected results in command order
  logic [15:0] expCmd [$];
  logic [7:0]  expResp [$];
  logic [2:0]  expX [$];
  logic [2:0]  expY [$];
  int          testCmds;
  int          testResps;
  int          testErrs;
  int          testStalls;

  function automatic string testName(input int id);
    case (id)
      0:       return "calibrate";
      1:       return "startTour";
      2:       return "legalMoves";
      3:       return "illegalCmds";
      default: return "backToBackBurst";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model of one command
  ////////////////////////////////////////////////////////////
  function automatic void predict(input knightCmdU cmd, input logic [2:0] x,
                                  input logic [2:0] y, output logic [7:0] resp,
                                  output logic [2:0] nx, output logic [2:0] ny);
    int dx;
    int dy;
    int n;
    int tx;
    int ty;
    nx   = x;
    ny   = y;
    resp = `ACK_NEG;
    dx   = 0;
    dy   = 0;
    n    = int'(cmd.move.squares);
    if (cmd.move.opcode == `OP_CAL) begin
      resp = `ACK_POS;
    end else if (cmd.tour.opcode == `OP_TOUR) begin
      // Only the low 3 bits of each coordinate count
      nx   = cmd.tour.startX[2:0];
      ny   = cmd.tour.startY[2:0];
      resp = `ACK_POS;
    end else if (cmd.move.opcode == `OP_MOVE) begin
      case (cmd.move.heading)
        `HDG_NORTH: dy = 1;
        `HDG_SOUTH: dy = -1;
        `HDG_EAST:  dx = 1;
        `HDG_WEST:  dx = -1;
        default:    dx = 0;
      endcase
      tx = int'(x) + dx * n;
      ty = int'(y) + dy * n;
      // Known heading, nonzero count, and the target stays on the board
      if ((dx != 0 || dy != 0) && n > 0 && tx >= 0 && tx <= 7 && ty >= 0 && ty <= 7) begin
        resp = `ACK_POS;
        nx   = tx[2:0];
        ny   = ty[2:0];
      end
    end
  endfunction

  task automatic logError(input string line);
    $display("%s", line);
    errCount++;
    testErrs++;
  endtask

  ////////////////////////////////////////////////////////////
  // Watch the DUT between edges where everything is settled
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : watch
    knightCmdU  cmd;
    logic [7:0] r;
    logic [2:0] nx;
    logic [2:0] ny;
    if (!rstN) begin
      lowPhase   = 1'b0;
      planX      = 3'(`RESET_X);
      planY      = 3'(`RESET_Y);
      lastX      = posX;
      lastY      = posY;
      errCount   = 0;
      cmdCount   = 0;
      testCmds   = 0;
      testResps  = 0;
      testErrs   = 0;
      testStalls = 0;
    end else begin
      // Credit stall seen on the byte port
      if (rxValid && !rxReady)
        testStalls++;
      // Byte taken on the coming edge
      if (rxValid && rxReady) begin
        if (!lowPhase) begin
          hiByte = rxByte;
        end else begin
          cmd = {hiByte, rxByte};
          predict(cmd, planX, planY, r, nx, ny);
          expCmd.push_back(cmd);
          expResp.push_back(r);
          expX.push_back(nx);
          expY.push_back(ny);
          planX = nx;
          planY = ny;
          cmdCount++;
          testCmds++;
        end
        lowPhase = !lowPhase;
      end
      if (respValid) begin
        if (expResp.size() == 0) begin
          logError($sformatf("%s: response %02h with no command outstanding",
                             testName(testId), respByte));
        end else begin
          cmd = expCmd.pop_front();
          r   = expResp.pop_front();
          nx  = expX.pop_front();
          ny  = expY.pop_front();
          testResps++;
          if (respByte !== r)
            logError($sformatf("[FAIL] %s cmd %04h respByte expected %02h actual %02h",
                               testName(testId), cmd, r, respByte));
          if (posX !== nx || posY !== ny)
            logError($sformatf("[FAIL] %s cmd %04h square expected (%0d,%0d) actual (%0d,%0d)",
                               testName(testId), cmd, nx, ny, posX, posY));
        end
        lastX = posX;
        lastY = posY;
      end else if (posX !== lastX || posY !== lastY) begin
        // Square may only move together with a response
        logError($sformatf("%s: square changed to (%0d,%0d) without a response",
                           testName(testId), posX, posY));
        lastX = posX;
        lastY = posY;
      end
      if (testEnd) begin
        if (testId == 4 && testStalls == 0)
          logError("backToBackBurst: rxReady never went low during the burst");
        $display("%s: %s (%0d cmds, %0d resps, %0d stalls, %0d errors)",
                 testName(testId), (testErrs == 0) ? "ok" : "FAILED",
                 testCmds, testResps, testStalls, testErrs);
        testCmds   = 0;
        testResps  = 0;
        testErrs   = 0;
        testStalls = 0;
      end
      pending = expResp.size();
    end
  end

endmodule

`default_nettype wire

// File: tb/knightCmdTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "knightCmd_defs.svh"

module knightCmdTb;

  localparam int NumCal     = 3;
  localparam int NumTour    = 4;
  localparam int NumLegal   = 40;
  localparam int NumIllegal = 16;
  localparam int NumBurst   = 24;
  localparam int TotalCmds  = NumCal + NumTour + NumLegal + NumIllegal + NumBurst;
  // Worst case per command plus a little for reset
  localparam int WatchdogClks = TotalCmds * (`CAL_CYCLES + 15 * `MOVE_CYCLES + 10) + 20;

  logic       clk;
  logic       rstN;
  logic [7:0] rxByte;
  logic       rxValid;
  logic       rxReady;
  logic       respValid;
  logic [7:0] respByte;
  logic [2:0] posX;
  logic [2:0] posY;
  logic [2:0] planX;
  logic [2:0] planY;
  logic       testEnd;
  int         testId;
  int         pending;
  int         errCount;
  int         cmdCount;

  knightCmdTop u_knightCmdTop (
    .clk(clk), .rstN(rstN),
    .rxByte(rxByte), .rxValid(rxValid), .rxReady(rxReady),
    .respValid(respValid), .respByte(respByte),
    .posX(posX), .posY(posY)
  );

  knightCmdChecker u_knightCmdChecker (
    .clk(clk), .rstN(rstN),
    .rxByte(rxByte), .rxValid(rxValid), .rxReady(rxReady),
    .respValid(respValid), .respByte(respByte),
    .posX(posX), .posY(posY),
    .testId(testId), .testEnd(testEnd),
    .pending(pending), .errCount(errCount), .cmdCount(cmdCount),
    .planX(planX), .planY(planY)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog
  initial begin
    repeat (WatchdogClks) @(posedge clk);
    $display("Watchdog expired after %0d clocks, the DUT stopped accepting or responding",
             WatchdogClks);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [7:0] headingCode(input int idx);
    case (idx)
      0:       return `HDG_NORTH;
      1:       return `HDG_WEST;
      2:       return `HDG_SOUTH;
      default: return `HDG_EAST;
    endcase
  endfunction

  // Free squares between a square and the edge along a heading
  function automatic int roomToEdge(input int idx, input logic [2:0] x, input logic [2:0] y);
    case (idx)
      0:       return 7 - int'(y);
      1:       return int'(x);
      2:       return int'(y);
      default: return 7 - int'(x);
    endcase
  endfunction

  // Hold the byte until the DUT is ready, return 1 ns after the taking edge
  task automatic sendByte(input logic [7:0] b);
    rxByte  = b;
    rxValid = 1'b1;
    @(negedge clk);
    while (!rxReady)
      @(negedge clk);
    @(posedge clk);
    #1;
    rxValid = 1'b0;
  endtask

  task automatic sendCommand(input logic [15:0] cmd, input bit backToBack);
    int gap;
    sendByte(cmd[15:8]);
    gap = backToBack ? 0 : $urandom_range(3, 0);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    sendByte(cmd[7:0]);
    gap = backToBack ? 0 : $urandom_range(3, 0);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Wait for every response, then let the checker close the test
  task automatic finishTest();
    while (pending != 0)
      @(posedge clk);
    #1;
    testEnd = 1'b1;
    @(posedge clk);
    #1;
    testEnd = 1'b0;
    testId++;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [15:0] cmd;
    logic [7:0]  hdg;
    logic [3:0]  op;
    int          h;
    int          room;
    int          kind;
    rstN    = 1'b0;
    rxValid = 1'b0;
    rxByte  = 8'h00;
    testEnd = 1'b0;
    testId  = 0;
    void'($urandom(32'h5673_e03a));
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    repeat (2) begin
      @(posedge clk);
      #1;
    end

    for (int i = 0; i < NumCal; i++)
      sendCommand({`OP_CAL, 12'($urandom)}, 1'b0);
    finishTest();

    // Start squares with junk in the reserved and upper coordinate bits
    for (int i = 0; i < NumTour; i++)
      sendCommand({`OP_TOUR, 12'($urandom)}, 1'b0);
    finishTest();

    // Legal moves chosen from the square the model expects
    for (int i = 0; i < NumLegal; i++) begin
      h = $urandom_range(3, 0);
      while (roomToEdge(h, planX, planY) == 0)
        h = (h + 1) % 4;
      room = roomToEdge(h, planX, planY);
      sendCommand({`OP_MOVE, headingCode(h), 4'($urandom_range(room, 1))}, 1'b0);
    end
    finishTest();

    // Off board, unknown heading, zero count, unknown opcode in turn
    for (int i = 0; i < NumIllegal; i++) begin
      kind = i % 4;
      h    = $urandom_range(3, 0);
      room = roomToEdge(h, planX, planY);
      case (kind)
        0: cmd = {`OP_MOVE, headingCode(h), 4'($urandom_range(15, room + 1))};
        1: begin
          hdg = 8'($urandom);
          while (hdg == `HDG_NORTH || hdg == `HDG_WEST || hdg == `HDG_SOUTH ||
                 hdg == `HDG_EAST)
            hdg = hdg + 8'd1;
          cmd = {`OP_MOVE, hdg, 4'($urandom_range(7, 1))};
        end
        2: cmd = {`OP_MOVE, headingCode(h), 4'h0};
        default: begin
          op = 4'($urandom);
          while (op == `OP_CAL || op == `OP_MOVE || op == `OP_TOUR)
            op = op + 4'd1;
          cmd = {op, 12'($urandom)};
        end
      endcase
      sendCommand(cmd, 1'b0);
    end
    finishTest();

    // Back-to-back mix, mostly runs to the far edge
    for (int i = 0; i < NumBurst; i++) begin
      kind = $urandom_range(9, 0);
      if (kind < 5) begin
        h = $urandom_range(3, 0);
        while (roomToEdge(h, planX, planY) == 0)
          h = (h + 1) % 4;
        cmd = {`OP_MOVE, headingCode(h), 4'(roomToEdge(h, planX, planY))};
      end else if (kind < 7) begin
        cmd = {`OP_CAL, 12'($urandom)};
      end else if (kind < 8) begin
        cmd = {`OP_TOUR, 12'($urandom)};
      end else begin
        cmd = 16'($urandom);
      end
      sendCommand(cmd, 1'b1);
    end
    finishTest();

    $display("Summary: %0d tests, %0d commands, %0d errors", testId, cmdCount, errCount);
    if (errCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/knightPkg.sv
hdl/cmdAssembler.sv
hdl/cmdFifo.sv
hdl/moveExecutor.sv
hdl/knightCmdTop.sv
tb/knightCmdChecker.sv
tb/knightCmdTb.sv

// File: Makefile
# Verilator simulation of the knight command path

VERILATOR ?= verilator
TOP       ?= knightCmdTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# Build, run, then pass only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
